// ==== rtl/sat_pkg.sv ====
// sat solver shared types
package sat_pkg;

    localparam int NUM_VARS = 8;
    localparam int LVL_W = 4;
    localparam int VAR_W = $clog2(NUM_VARS);

    // both masks zero mark an empty slot
    typedef struct packed {
        logic [NUM_VARS-1:0] pos;
        logic [NUM_VARS-1:0] neg;
    } clause_t;

    typedef struct packed {
        logic             assigned;
        logic             value;
        logic             decision;
        logic             flipped;
        logic [LVL_W-1:0] lvl;
    } var_state_t;

    typedef struct packed {
        logic [VAR_W-1:0] idx;
        logic             pol;
    } lit_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_DECIDE,
        OP_IMPLY,
        OP_BACKTRACK
    } op_t;

endpackage

// ==== rtl/clause_array.sv ====
// clause storage and evaluation
`timescale 1ns/10ps

module clause_array #(
    parameter int NUM_CLAUSES = 8
) (
    input  logic                                            clk,
    input  logic                                            rst_i,
    input  logic                                            wr_i,
    input  logic [$clog2(NUM_CLAUSES)-1:0]                  wr_idx_i,
    input  sat_pkg::clause_t                                clause_i,
    input  logic [$clog2(NUM_CLAUSES)-1:0]                  rd_idx_i,
    input  sat_pkg::var_state_t [sat_pkg::NUM_VARS-1:0]     var_states_i,
    output sat_pkg::clause_t                                clause_o,
    output logic                                            conflict_o,
    output logic                                            unit_valid_o,
    output sat_pkg::lit_t                                   unit_lit_o,
    output logic                                            all_sat_o
);
    import sat_pkg::*;

    clause_t             clauses_q [NUM_CLAUSES];
    logic [NUM_VARS-1:0] asg;
    logic [NUM_VARS-1:0] val;
    logic [NUM_VARS-1:0] free_pos [NUM_CLAUSES];
    logic [NUM_VARS-1:0] free_neg [NUM_CLAUSES];
    logic [NUM_CLAUSES-1:0] c_used;
    logic [NUM_CLAUSES-1:0] c_sat;
    logic [NUM_CLAUSES-1:0] c_unit;
    logic [NUM_CLAUSES-1:0] c_conf;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int c = 0; c < NUM_CLAUSES; c++) begin
                clauses_q[c] <= '0;
            end
        end else if (wr_i) begin
            clauses_q[wr_idx_i] <= clause_i;
        end
    end

    assign clause_o = clauses_q[rd_idx_i];

    always_comb begin
        for (int v = 0; v < NUM_VARS; v++) begin
            asg[v] = var_states_i[v].assigned;
            val[v] = var_states_i[v].value;
        end
    end

    // every clause checked in parallel
    for (genvar c = 0; c < NUM_CLAUSES; c++) begin : g_eval
        logic [2*NUM_VARS-1:0] free_lits;
        logic [2*NUM_VARS-1:0] true_lits;

        assign free_pos[c] = clauses_q[c].pos & ~asg;
        assign free_neg[c] = clauses_q[c].neg & ~asg;
        assign free_lits = {free_pos[c], free_neg[c]};
        assign true_lits = {clauses_q[c].pos & asg & val, clauses_q[c].neg & asg & ~val};

        assign c_used[c] = |{clauses_q[c].pos, clauses_q[c].neg};
        assign c_sat[c] = |true_lits;
        // exactly one free literal left
        assign c_unit[c] = c_used[c] && !c_sat[c] && (free_lits != '0)
                           && ((free_lits & (free_lits - 1'b1)) == '0);
        assign c_conf[c] = c_used[c] && !c_sat[c] && (free_lits == '0);
    end

    assign conflict_o = |c_conf;
    assign unit_valid_o = |c_unit;
    assign all_sat_o = &(c_sat | ~c_used);

    // descending scan so the lowest unit clause wins
    always_comb begin
        unit_lit_o = '0;
        for (int c = NUM_CLAUSES - 1; c >= 0; c--) begin
            if (c_unit[c]) begin
                for (int v = 0; v < NUM_VARS; v++) begin
                    if (free_pos[c][v]) begin
                        unit_lit_o.idx = VAR_W'(v);
                        unit_lit_o.pol = 1'b1;
                    end
                    if (free_neg[c][v]) begin
                        unit_lit_o.idx = VAR_W'(v);
                        unit_lit_o.pol = 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/state_list.sv ====
// variable assignment state list
`timescale 1ns/10ps

module state_list (
    input  logic                                            clk,
    input  logic                                            rst_i,
    input  logic                                            clear_i,
    input  sat_pkg::op_t                                    op_i,
    input  sat_pkg::lit_t                                   unit_lit_i,
    output sat_pkg::var_state_t [sat_pkg::NUM_VARS-1:0]     var_states_o,
    output logic [sat_pkg::LVL_W-1:0]                       level_o,
    output logic                                            bkt_fail_o
);
    import sat_pkg::*;

    var_state_t [NUM_VARS-1:0] vs_q;
    logic [LVL_W-1:0]          level_q;
    logic [LVL_W-1:0]          next_level;

    logic                      dec_found;
    logic [VAR_W-1:0]          dec_idx;
    logic                      bkt_found;
    logic [VAR_W-1:0]          bkt_idx;
    logic [LVL_W-1:0]          bkt_lvl;

    assign next_level = level_q + 1'b1;

    // lowest unassigned variable
    always_comb begin
        dec_found = 1'b0;
        dec_idx = '0;
        for (int v = NUM_VARS - 1; v >= 0; v--) begin
            if (!vs_q[v].assigned) begin
                dec_found = 1'b1;
                dec_idx = VAR_W'(v);
            end
        end
    end

    // deepest decision still holding its first value
    always_comb begin
        bkt_found = 1'b0;
        bkt_idx = '0;
        bkt_lvl = '0;
        for (int v = 0; v < NUM_VARS; v++) begin
            if (vs_q[v].assigned && vs_q[v].decision && !vs_q[v].flipped
                && (!bkt_found || vs_q[v].lvl > bkt_lvl)) begin
                bkt_found = 1'b1;
                bkt_idx = VAR_W'(v);
                bkt_lvl = vs_q[v].lvl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            vs_q <= '0;
            level_q <= '0;
        end else begin
            case (op_i)
                OP_DECIDE: begin
                    if (dec_found) begin
                        vs_q[dec_idx] <= '{
                            assigned: 1'b1,
                            value:    1'b0,
                            decision: 1'b1,
                            flipped:  1'b0,
                            lvl:      next_level
                        };
                        level_q <= next_level;
                    end
                end
                OP_IMPLY: begin
                    vs_q[unit_lit_i.idx] <= '{
                        assigned: 1'b1,
                        value:    unit_lit_i.pol,
                        decision: 1'b0,
                        flipped:  1'b0,
                        lvl:      level_q
                    };
                end
                OP_BACKTRACK: begin
                    if (bkt_found) begin
                        for (int v = 0; v < NUM_VARS; v++) begin
                            if (VAR_W'(v) == bkt_idx) begin
                                // try the other branch at the same level
                                vs_q[v].value <= ~vs_q[v].value;
                                vs_q[v].flipped <= 1'b1;
                            end else if (vs_q[v].assigned && vs_q[v].lvl >= bkt_lvl) begin
                                vs_q[v] <= '0;
                            end
                        end
                        level_q <= bkt_lvl;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign var_states_o = vs_q;
    assign level_o = level_q;
    assign bkt_fail_o = !bkt_found;

endmodule

// ==== rtl/ctrl_core.sv ====
// dpll search control
`timescale 1ns/10ps

module ctrl_core (
    input  logic         clk,
    input  logic         rst_i,
    input  logic         start_i,
    input  logic         conflict_i,
    input  logic         unit_valid_i,
    input  logic         all_sat_i,
    input  logic         bkt_fail_i,
    output sat_pkg::op_t op_o,
    output logic         clear_o,
    output logic         busy_o,
    output logic         done_o,
    output logic         sat_o,
    output logic         unsat_o
);
    import sat_pkg::*;

    // busy_q is the idle/running state
    logic busy_q;
    logic done_q;
    logic sat_q;
    logic unsat_q;
    logic finish_sat;
    logic finish_unsat;

    // one op per cycle by fixed priority
    always_comb begin
        op_o = OP_NONE;
        finish_sat = 1'b0;
        finish_unsat = 1'b0;
        if (busy_q) begin
            if (conflict_i) begin
                if (bkt_fail_i) begin
                    finish_unsat = 1'b1;
                end else begin
                    op_o = OP_BACKTRACK;
                end
            end else if (unit_valid_i) begin
                op_o = OP_IMPLY;
            end else if (all_sat_i) begin
                finish_sat = 1'b1;
            end else begin
                op_o = OP_DECIDE;
            end
        end
    end

    assign clear_o = start_i && !busy_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            sat_q <= 1'b0;
            unsat_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                if (start_i) begin
                    busy_q <= 1'b1;
                    sat_q <= 1'b0;
                    unsat_q <= 1'b0;
                end
            end else if (finish_sat || finish_unsat) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
                sat_q <= finish_sat;
                unsat_q <= finish_unsat;
            end
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;
    assign sat_o = sat_q;
    assign unsat_o = unsat_q;

endmodule

// ==== rtl/sat_engine.sv ====
// sat solver engine top
`timescale 1ns/10ps

module sat_engine #(
    parameter int NUM_CLAUSES = 8
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              wr_clause_i,
    input  logic [$clog2(NUM_CLAUSES)-1:0]    clause_idx_i,
    input  sat_pkg::clause_t                  clause_i,
    input  logic [$clog2(NUM_CLAUSES)-1:0]    rd_idx_i,
    output sat_pkg::clause_t                  clause_o,
    input  logic                              start_i,
    output logic                              busy_o,
    output logic                              done_o,
    output logic                              sat_o,
    output logic                              unsat_o,
    output logic [sat_pkg::NUM_VARS-1:0]      var_value_o,
    output logic [sat_pkg::NUM_VARS-1:0]      var_assigned_o,
    output logic [sat_pkg::LVL_W-1:0]         level_o
);
    import sat_pkg::*;

    var_state_t [NUM_VARS-1:0] var_states;
    op_t                       op;
    lit_t                      unit_lit;
    logic                      clear;
    logic                      conflict;
    logic                      unit_valid;
    logic                      all_sat;
    logic                      bkt_fail;

    ctrl_core u_ctrl_core (
        .clk          (clk),
        .rst_i        (rst_i),
        .start_i      (start_i),
        .conflict_i   (conflict),
        .unit_valid_i (unit_valid),
        .all_sat_i    (all_sat),
        .bkt_fail_i   (bkt_fail),
        .op_o         (op),
        .clear_o      (clear),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .sat_o        (sat_o),
        .unsat_o      (unsat_o)
    );

    state_list u_state_list (
        .clk          (clk),
        .rst_i        (rst_i),
        .clear_i      (clear),
        .op_i         (op),
        .unit_lit_i   (unit_lit),
        .var_states_o (var_states),
        .level_o      (level_o),
        .bkt_fail_o   (bkt_fail)
    );

    clause_array #(
        .NUM_CLAUSES (NUM_CLAUSES)
    ) u_clause_array (
        .clk          (clk),
        .rst_i        (rst_i),
        .wr_i         (wr_clause_i),
        .wr_idx_i     (clause_idx_i),
        .clause_i     (clause_i),
        .rd_idx_i     (rd_idx_i),
        .var_states_i (var_states),
        .clause_o     (clause_o),
        .conflict_o   (conflict),
        .unit_valid_o (unit_valid),
        .unit_lit_o   (unit_lit),
        .all_sat_o    (all_sat)
    );

    // flatten the assignment for the result ports
    always_comb begin
        for (int v = 0; v < NUM_VARS; v++) begin
            var_value_o[v] = var_states[v].value;
            var_assigned_o[v] = var_states[v].assigned;
        end
    end

endmodule

// ==== dv/sat_engine_assert.sv ====
// sat engine protocol assertions
`timescale 1ns/10ps

module sat_engine_assert (
    input logic clk,
    input logic rst_i,
    input logic wr_clause_i,
    input logic busy_o,
    input logic done_o,
    input logic sat_o,
    input logic unsat_o
);

    a_done_pulse: assert property (@(posedge clk) disable iff (rst_i) done_o |=> !done_o)
        else $error("done_o held high for more than one cycle");

    a_one_verdict: assert property (@(posedge clk) disable iff (rst_i) !(sat_o && unsat_o))
        else $error("sat_o and unsat_o high together");

    // clause writes only between searches
    a_write_idle: assert property (@(posedge clk) disable iff (rst_i) !(wr_clause_i && busy_o))
        else $error("clause write while busy");

endmodule

bind sat_engine sat_engine_assert u_sva (
    .clk         (clk),
    .rst_i       (rst_i),
    .wr_clause_i (wr_clause_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .sat_o       (sat_o),
    .unsat_o     (unsat_o)
);

// ==== dv/sat_engine_tb.sv ====
// sat engine testbench
`timescale 1ns/10ps

module sat_engine_tb;
    import sat_pkg::*;

    localparam int NUM_CLAUSES = 8;
    localparam int IDX_W = $clog2(NUM_CLAUSES);
    localparam int NUM_PROBLEMS = 200;
    localparam int MAX_CYCLES = 6000;
    localparam int CLK_PERIOD = 8;
    localparam int WATCHDOG_NS = (NUM_PROBLEMS + 4) * MAX_CYCLES * CLK_PERIOD;

    logic              clk = 1'b0;
    logic              rst_i;
    logic              wr_clause_i;
    logic [IDX_W-1:0]  clause_idx_i;
    clause_t           clause_i;
    logic [IDX_W-1:0]  rd_idx_i;
    clause_t           clause_o;
    logic              start_i;
    logic              busy_o;
    logic              done_o;
    logic              sat_o;
    logic              unsat_o;
    logic [NUM_VARS-1:0] var_value_o;
    logic [NUM_VARS-1:0] var_assigned_o;
    logic [LVL_W-1:0]  level_o;

    integer            seed = 32'h28d9_822c;
    clause_t           prob [NUM_CLAUSES];
    logic              first_sat;
    logic [NUM_VARS-1:0] first_value;
    logic [NUM_VARS-1:0] first_assigned;
    logic [LVL_W-1:0]  first_level;

    sat_engine #(.NUM_CLAUSES(NUM_CLAUSES)) dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, act, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // brute force over every assignment
    function automatic logic model_sat();
        logic [NUM_VARS-1:0] a;
        logic ok;
        for (int i = 0; i < 2 ** NUM_VARS; i++) begin
            a = NUM_VARS'(i);
            ok = 1'b1;
            for (int c = 0; c < NUM_CLAUSES; c++) begin
                if ((prob[c].pos | prob[c].neg) != '0
                    && ((prob[c].pos & a) | (prob[c].neg & ~a)) == '0)
                    ok = 1'b0;
            end
            if (ok)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic clause_covered(input int c);
        return |((prob[c].pos & var_assigned_o & var_value_o)
                 | (prob[c].neg & var_assigned_o & ~var_value_o));
    endfunction

    task automatic random_problem();
        logic [31:0] r;
        logic [31:0] sel;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            r = $random(seed);
            sel = $random(seed);
            prob[c] = '0;
            // roughly a quarter of the slots stay empty
            if (r[1:0] != 2'd0) begin
                for (int v = 0; v < NUM_VARS; v++) begin
                    if (sel[3*v +: 3] == 3'd0)
                        prob[c].pos[v] = 1'b1;
                    else if (sel[3*v +: 3] == 3'd1)
                        prob[c].neg[v] = 1'b1;
                end
            end
        end
    endtask

    task automatic load_problem();
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            wr_clause_i = 1'b1;
            clause_idx_i = IDX_W'(c);
            clause_i = prob[c];
            @(negedge clk);
        end
        wr_clause_i = 1'b0;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            rd_idx_i = IDX_W'(c);
            #1;
            check($sformatf("clause_o[%0d]", c), 32'(clause_o), 32'(prob[c]));
            @(negedge clk);
        end
    endtask

    // pulse start and wait for done at a falling edge
    task automatic run_search();
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        check("busy_o", 32'(busy_o), 32'd1);
        while (!done_o)
            @(negedge clk);
    endtask

    task automatic check_result();
        logic exp;
        exp = model_sat();
        check("busy_o", 32'(busy_o), 32'd0);
        check("sat_o", 32'(sat_o), 32'(exp));
        check("unsat_o", 32'(unsat_o), 32'(!exp));
        if (sat_o) begin
            for (int c = 0; c < NUM_CLAUSES; c++) begin
                if ((prob[c].pos | prob[c].neg) != '0)
                    check($sformatf("var_value_o clause %0d", c), 32'(clause_covered(c)), 32'd1);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: the search never finished");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        rst_i = 1'b1;
        wr_clause_i = 1'b0;
        clause_idx_i = '0;
        clause_i = '0;
        rd_idx_i = '0;
        start_i = 1'b0;
        repeat (5) @(negedge clk);
        rst_i = 1'b0;

        check("busy_o", 32'(busy_o), 32'd0);
        check("done_o", 32'(done_o), 32'd0);
        check("sat_o", 32'(sat_o), 32'd0);
        check("unsat_o", 32'(unsat_o), 32'd0);
        check("var_assigned_o", 32'(var_assigned_o), 32'd0);
        check("level_o", 32'(level_o), 32'd0);
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            rd_idx_i = IDX_W'(c);
            #1;
            check($sformatf("clause_o[%0d]", c), 32'(clause_o), 32'd0);
            @(negedge clk);
        end

        // all slots empty
        for (int c = 0; c < NUM_CLAUSES; c++)
            prob[c] = '0;
        load_problem();
        run_search();
        check("sat_o", 32'(sat_o), 32'd1);
        check("level_o", 32'(level_o), 32'd0);
        check_result();

        // x0 and not x0
        prob[0].pos = NUM_VARS'(1);
        prob[1].neg = NUM_VARS'(1);
        load_problem();
        run_search();
        check("unsat_o", 32'(unsat_o), 32'd1);
        check("level_o", 32'(level_o), 32'd0);
        check_result();

        for (int p = 0; p < NUM_PROBLEMS; p++) begin
            random_problem();
            load_problem();
            run_search();
            check_result();
        end

        // rerun the same clauses
        first_sat = sat_o;
        first_value = var_value_o;
        first_assigned = var_assigned_o;
        first_level = level_o;
        run_search();
        check("sat_o", 32'(sat_o), 32'(first_sat));
        check("var_value_o", 32'(var_value_o), 32'(first_value));
        check("var_assigned_o", 32'(var_assigned_o), 32'(first_assigned));
        check("level_o", 32'(level_o), 32'(first_level));

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sat_engine.f ====
rtl/sat_pkg.sv
rtl/clause_array.sv
rtl/state_list.sv
rtl/ctrl_core.sv
rtl/sat_engine.sv
dv/sat_engine_assert.sv
dv/sat_engine_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sat_engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sat_engine.f --top-module sat_engine_tb

output=$(./obj_dir/Vsat_engine_tb) || true
echo "$output"

if echo "$output" | grep -q "TEST PASS"; then
    exit 0
fi
exit 1
